//--- common/axil_pkg.sv
/*
 * AXI-lite bus definitions shared by the register slave, the top level and the testbench.
 * Refer to the items by scoped name, for example axil_pkg::resp_okay.
 */
`default_nettype none

package axil_pkg;

    // Data bus width in bits
    // The slave stores one full data word per register
    localparam int axil_data_width = 32;

    // Byte address width
    localparam int axil_addr_width = 32;

    // Response codes on B and R
    // Only OKAY and SLVERR are ever issued
    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

//--- common/enable_gen_pkg.sv
/*
 * Enable generator definitions: the default counter width and the register map.
 * The byte address of a register is the base address plus four times its index.
 */
`default_nettype none

package enable_gen_pkg;

    // Default width of the period counter
    // The top level may narrow it but never widen it past the data bus
    localparam int counter_width_default = 32;

    // Size of the register block seen by the bus
    localparam int n_registers = 4;

    // Register indices inside the block

    // Bit 0 starts the counter from the bus, the other bits are not stored
    localparam int reg_enable = 0;

    // Terminal count, one counter period lasts period+1 clocks
    localparam int reg_period = 1;

    // Count at which the first enable strobe fires
    localparam int reg_threshold_1 = 2;

    // Count at which the second enable strobe fires
    localparam int reg_threshold_2 = 3;

endpackage

`default_nettype wire

//--- axil_register_cu/axil_register_cu.sv
/*
 * AXI-lite slave holding a block of 32-bit write registers and returning read-back words.
 * Writes land in registers, reads are served from the read_values vector given by the parent.
 */
`default_nettype none
`timescale 1ns/1ns

module axil_register_cu #(
    parameter int n_registers = enable_gen_pkg::n_registers,
    parameter logic [axil_pkg::axil_addr_width-1:0] base_address = '0
) (
    input  logic clock,
    input  logic rst,

    // Write address channel
    input  logic [axil_pkg::axil_addr_width-1:0] awaddr,
    input  logic awvalid,
    output logic awready,

    // Write data channel
    // Write strobes are not decoded because every write replaces the full word
    input  logic [axil_pkg::axil_data_width-1:0] wdata,
    input  logic [axil_pkg::axil_data_width/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,

    // Write response channel
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,

    // Read address channel
    input  logic [axil_pkg::axil_addr_width-1:0] araddr,
    input  logic arvalid,
    output logic arready,

    // Read data channel
    output logic [axil_pkg::axil_data_width-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,

    // Flat register vectors, register i sits at bits [32*i +: 32]
    input  logic [n_registers*axil_pkg::axil_data_width-1:0] read_values,
    output logic [n_registers*axil_pkg::axil_data_width-1:0] registers
);

    localparam int data_width = axil_pkg::axil_data_width;
    localparam int addr_width = axil_pkg::axil_addr_width;

    // Number of address bits that select a byte inside one register
    localparam int lane_bits = $clog2(data_width / 8);

    // Register index width, kept at one bit for a single-register block
    localparam int index_width = (n_registers > 1) ? $clog2(n_registers) : 1;

    // Span of the block in bytes
    localparam logic [addr_width-1:0] block_size = addr_width'(n_registers * (data_width / 8));

    logic write_accept;
    logic read_accept;
    logic aw_in_range;
    logic ar_in_range;
    logic [index_width-1:0] aw_index;
    logic [index_width-1:0] ar_index;

    // True when the byte address falls inside the register block
    // The lower bound is checked on its own since the subtraction wraps
    function automatic logic addr_in_block(input logic [addr_width-1:0] addr);
        logic [addr_width-1:0] offset;
        offset = addr - base_address;
        return (addr >= base_address) && (offset < block_size);
    endfunction

    // Register index of a byte address, meaningful only inside the block
    // Low address bits below a word are dropped
    function automatic logic [index_width-1:0] addr_index(input logic [addr_width-1:0] addr);
        logic [addr_width-1:0] offset;
        offset = addr - base_address;
        return offset[lane_bits +: index_width];
    endfunction

    assign aw_in_range = addr_in_block(awaddr);
    assign ar_in_range = addr_in_block(araddr);
    assign aw_index = addr_index(awaddr);
    assign ar_index = addr_index(araddr);

    // A write is taken only with both address and data present and no response waiting
    // The ready pair is high for exactly the cycle that ends in the transfer
    assign write_accept = awvalid && wvalid && !bvalid;
    assign awready = write_accept;
    assign wready = write_accept;

    // A read is taken whenever the previous read data has been consumed
    assign read_accept = arvalid && !rvalid;
    assign arready = read_accept;

    // Register storage and write response handshake
    always_ff @(posedge clock) begin
        if (rst) begin
            registers <= '0;
            bvalid <= 1'b0;
        end else if (write_accept) begin
            // Writes outside the block are dropped and answered with SLVERR
            if (aw_in_range) begin
                registers[aw_index*data_width +: data_width] <= wdata;
            end
            bvalid <= 1'b1;
        end else if (bvalid && bready) begin
            bvalid <= 1'b0;
        end
    end

    // Write response code, only looked at while bvalid is high
    always_ff @(posedge clock) begin
        if (write_accept) begin
            bresp <= aw_in_range ? axil_pkg::resp_okay : axil_pkg::resp_slverr;
        end
    end

    // Read data handshake
    always_ff @(posedge clock) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (read_accept) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read payload is sampled when the address is taken and held until rready
    // Out-of-range reads return zero with SLVERR
    always_ff @(posedge clock) begin
        if (read_accept) begin
            if (ar_in_range) begin
                rdata <= read_values[ar_index*data_width +: data_width];
                rresp <= axil_pkg::resp_okay;
            end else begin
                rdata <= '0;
                rresp <= axil_pkg::resp_slverr;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/enable_generator_counter.sv
/*
 * Wrapping period counter for the enable generator.
 * Counts 0..period while enabled and clears to zero as soon as the enable drops.
 */
`default_nettype none
`timescale 1ns/1ns

module enable_generator_counter #(
    parameter int counter_width = enable_gen_pkg::counter_width_default
) (
    input  logic clock,
    input  logic rst,
    input  logic gen_enable_in,
    input  logic [counter_width-1:0] period,
    output logic [counter_width-1:0] count,
    output logic running
);

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
            running <= 1'b0;
        end else if (!gen_enable_in) begin
            // Stopped counter sits at zero so the next start is aligned
            count <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            // Wrap on the edge after the terminal value is reached
            // A period lowered below the live count lets it run on to the natural rollover
            if (count == period) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/enable_comparator.sv
/*
 * Threshold comparator producing a registered one-cycle enable strobe.
 * Fires on the cycle after the running count equals enable_threshold.
 */
`default_nettype none
`timescale 1ns/1ns

module enable_comparator #(
    parameter int counter_width = enable_gen_pkg::counter_width_default
) (
    input  logic clock,
    input  logic rst,
    input  logic running,
    input  logic [counter_width-1:0] count,
    input  logic [counter_width-1:0] enable_threshold,
    output logic enable_out
);

    // Registered match so the strobe is clean and aligned to the clock edge
    // A threshold above the period is never reached and the strobe stays low
    always_ff @(posedge clock) begin
        if (rst) begin
            enable_out <= 1'b0;
        end else begin
            enable_out <= running && (count == enable_threshold);
        end
    end

endmodule

`default_nettype wire

//--- hdl/enable_generator_2.sv
/*
 * Top level of the two-phase enable generator with its AXI-lite register block.
 * Set base_address and counter_width, then drive gen_enable_in or the bus enable bit.
 */
`default_nettype none
`timescale 1ns/1ns

module enable_generator_2 #(
    parameter logic [axil_pkg::axil_addr_width-1:0] base_address = '0,
    parameter int counter_width = enable_gen_pkg::counter_width_default
) (
    input  logic clock,
    input  logic rst,
    input  logic gen_enable_in,
    output logic enable_out_1,
    output logic enable_out_2,

    // AXI-lite slave port
    input  logic [axil_pkg::axil_addr_width-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [axil_pkg::axil_data_width-1:0] wdata,
    input  logic [axil_pkg::axil_data_width/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [axil_pkg::axil_addr_width-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [axil_pkg::axil_data_width-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready
);

    localparam int data_width = axil_pkg::axil_data_width;
    localparam int n_registers = enable_gen_pkg::n_registers;

    logic [n_registers*data_width-1:0] registers;
    logic [n_registers*data_width-1:0] read_values;

    logic bus_enable;
    logic counter_enable;
    logic [counter_width-1:0] period;
    logic [counter_width-1:0] enable_threshold_1;
    logic [counter_width-1:0] enable_threshold_2;
    logic [counter_width-1:0] count;
    logic running;

    axil_register_cu #(
        .n_registers(n_registers),
        .base_address(base_address)
    ) register_cu (
        .clock(clock),
        .rst(rst),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .read_values(read_values),
        .registers(registers)
    );

    // Only the low counter_width bits of period and thresholds reach the datapath
    assign bus_enable = registers[enable_gen_pkg::reg_enable*data_width];
    assign period = registers[enable_gen_pkg::reg_period*data_width +: counter_width];
    assign enable_threshold_1 =
        registers[enable_gen_pkg::reg_threshold_1*data_width +: counter_width];
    assign enable_threshold_2 =
        registers[enable_gen_pkg::reg_threshold_2*data_width +: counter_width];

    // Read-back shows what the hardware actually uses, upper bits read as zero
    always_comb begin
        read_values = '0;
        read_values[enable_gen_pkg::reg_enable*data_width] = bus_enable;
        read_values[enable_gen_pkg::reg_period*data_width +: counter_width] = period;
        read_values[enable_gen_pkg::reg_threshold_1*data_width +: counter_width] =
            enable_threshold_1;
        read_values[enable_gen_pkg::reg_threshold_2*data_width +: counter_width] =
            enable_threshold_2;
    end

    // Either the external level or the bus bit keeps the counter running
    assign counter_enable = gen_enable_in | bus_enable;

    enable_generator_counter #(
        .counter_width(counter_width)
    ) counter (
        .clock(clock),
        .rst(rst),
        .gen_enable_in(counter_enable),
        .period(period),
        .count(count),
        .running(running)
    );

    // Two comparators on the same count give two phase-shifted strobes per period
    enable_comparator #(
        .counter_width(counter_width)
    ) comparator_1 (
        .clock(clock),
        .rst(rst),
        .running(running),
        .count(count),
        .enable_threshold(enable_threshold_1),
        .enable_out(enable_out_1)
    );

    enable_comparator #(
        .counter_width(counter_width)
    ) comparator_2 (
        .clock(clock),
        .rst(rst),
        .running(running),
        .count(count),
        .enable_threshold(enable_threshold_2),
        .enable_out(enable_out_2)
    );

endmodule

`default_nettype wire

//--- verif/enable_generator_tb.sv
/*
 * Random-stimulus testbench for the two-phase enable generator.
 * Drives the AXI-lite port and gen_enable_in, and checks reads and strobes against a cycle model.
 */
`default_nettype none
`timescale 1ns/1ns

module enable_generator_tb;

    localparam int clock_period = 40;
    localparam logic [31:0] base_address = 32'h4000;
    localparam int counter_width = 16;
    localparam int n_registers = enable_gen_pkg::n_registers;

    // Cycle budget of each test
    // The watchdog allows twice their sum
    localparam int txn_cycles = 10;
    localparam int reset_test_cycles = 10 + 4 * txn_cycles;
    localparam int readback_cycles = 10 * txn_cycles;
    localparam int range_cycles = 16 * txn_cycles;
    localparam int external_cycles = 3 * (3 * txn_cycles + 4 * 41 + 5);
    localparam int bus_cycles = 12 * txn_cycles + 3 * 65 + 130;
    localparam int reprogram_cycles = 8 * (2 * txn_cycles + 20) + 5;
    localparam int planned_cycles = 5 + reset_test_cycles + readback_cycles + range_cycles +
        external_cycles + bus_cycles + reprogram_cycles;

    logic clock = 1'b0;
    logic rst;
    logic gen_enable_in;
    logic enable_out_1;
    logic enable_out_2;
    logic [axil_pkg::axil_addr_width-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [axil_pkg::axil_data_width-1:0] wdata;
    logic [axil_pkg::axil_data_width/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [axil_pkg::axil_addr_width-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [axil_pkg::axil_data_width-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    integer seed;
    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;

    // Model state for the cycle that follows the last rising edge
    logic [counter_width-1:0] model_count = '0;
    logic model_running = 1'b0;
    logic model_out_1 = 1'b0;
    logic model_out_2 = 1'b0;
    logic [31:0] shadow [n_registers];

    enable_generator_2 #(
        .base_address(base_address),
        .counter_width(counter_width)
    ) DUT (
        .clock(clock), .rst(rst), .gen_enable_in(gen_enable_in),
        .enable_out_1(enable_out_1), .enable_out_2(enable_out_2),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin : clock_gen
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin : watchdog
        #(planned_cycles * 2 * clock_period);
        $display("timeout: the run did not finish within %0d clock cycles", planned_cycles * 2);
        $display("tests failed");
        $finish;
    end

    function automatic int random_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [31:0] register_address(input int index);
        return base_address + 32'(4 * index);
    endfunction

    // The block spans four words starting at the base address
    function automatic logic address_in_block(input logic [31:0] addr);
        return (addr >= base_address) && ((addr - base_address) < 32'(4 * n_registers));
    endfunction

    function automatic int address_index(input logic [31:0] addr);
        return int'((addr - base_address) >> 2);
    endfunction

    // Read-back keeps only bit 0 of the enable word and counter_width bits of the others
    function automatic logic [31:0] expected_read(input int index);
        if (index == enable_gen_pkg::reg_enable) begin
            return {31'b0, shadow[index][0]};
        end
        return shadow[index] & ((32'h1 << counter_width) - 1);
    endfunction

    task automatic compare_data(input logic [axil_pkg::axil_data_width-1:0] got,
                                input logic [axil_pkg::axil_data_width-1:0] expected,
                                input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got,
                expected);
            error_count++;
        end
    endtask

    task automatic compare_resp(input logic [1:0] got, input logic [1:0] expected,
                                input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s was %b, expected %b", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_enable(input logic got_1, input logic got_2,
                                  input logic expected_1, input logic expected_2);
        if (got_1 !== expected_1 || got_2 !== expected_2) begin
            $display("MISMATCH at %0t: enable outputs were %b%b, expected %b%b", $time,
                got_1, got_2, expected_1, expected_2);
            error_count++;
        end
    endtask

    // Mid-cycle the inputs for the coming edge are settled, so the model steps here
    always @(negedge clock) begin : cycle_model
        logic enable;
        logic [counter_width-1:0] model_period;
        logic [counter_width-1:0] threshold_1;
        logic [counter_width-1:0] threshold_2;
        compare_enable(enable_out_1, enable_out_2, model_out_1, model_out_2);
        enable = gen_enable_in | shadow[enable_gen_pkg::reg_enable][0];
        model_period = shadow[enable_gen_pkg::reg_period][counter_width-1:0];
        threshold_1 = shadow[enable_gen_pkg::reg_threshold_1][counter_width-1:0];
        threshold_2 = shadow[enable_gen_pkg::reg_threshold_2][counter_width-1:0];
        if (rst) begin
            model_count = '0;
            model_running = 1'b0;
            model_out_1 = 1'b0;
            model_out_2 = 1'b0;
            for (int i = 0; i < n_registers; i++) begin
                shadow[i] = '0;
            end
        end else begin
            // Strobes come from the count and thresholds as they stand before the edge
            model_out_1 = model_running && (model_count == threshold_1);
            model_out_2 = model_running && (model_count == threshold_2);
            if (!enable) begin
                model_count = '0;
                model_running = 1'b0;
            end else begin
                model_running = 1'b1;
                model_count = (model_count == model_period) ? '0 : model_count + 1'b1;
            end
            // A write handshake at the coming edge lands in the shadow copy
            if (awvalid && wvalid && awready && address_in_block(awaddr)) begin
                shadow[address_index(awaddr)] = wdata;
            end
        end
    end

    // All stimulus changes 2 ns after a rising edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int hold;
        hold = random_below(4);
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge clock);
        while (awready !== 1'b1) @(negedge clock);
        // Address and data are taken on the same edge, so both readies are high together
        if (wready !== 1'b1) begin
            $display("write data channel was not ready with the write address at %0t", $time);
            error_count++;
        end
        next_cycle();
        awvalid = 1'b0;
        wvalid = 1'b0;
        // Back-pressure on B before taking the response
        idle_cycles(hold);
        bready = 1'b1;
        @(negedge clock);
        while (bvalid !== 1'b1) @(negedge clock);
        resp = bresp;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int hold;
        hold = random_below(4);
        araddr = addr;
        arvalid = 1'b1;
        @(negedge clock);
        while (arready !== 1'b1) @(negedge clock);
        next_cycle();
        arvalid = 1'b0;
        idle_cycles(hold);
        rready = 1'b1;
        @(negedge clock);
        while (rvalid !== 1'b1) @(negedge clock);
        data = rdata;
        resp = rresp;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic write_reg(input int index, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(register_address(index), data, resp);
        compare_resp(resp, axil_pkg::resp_okay, $sformatf("write response of register %0d", index));
    endtask

    task automatic check_reg(input int index);
        logic [31:0] data;
        logic [1:0] resp;
        axil_read(register_address(index), data, resp);
        compare_resp(resp, axil_pkg::resp_okay, $sformatf("read response of register %0d", index));
        compare_data(data, expected_read(index), $sformatf("register %0d", index));
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0s: PASS", name);
        end else begin
            fail_count++;
            $display("test %0s: FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset_values();
        int errors_before;
        int index;
        logic [31:0] data;
        logic [1:0] resp;
        errors_before = error_count;
        for (index = 0; index < n_registers; index++) begin
            axil_read(register_address(index), data, resp);
            compare_resp(resp, axil_pkg::resp_okay, "read response after reset");
            compare_data(data, 32'h0, $sformatf("register %0d after reset", index));
        end
        idle_cycles(10);
        report_test("reset values", errors_before);
    endtask

    task automatic test_readback();
        int errors_before;
        int index;
        errors_before = error_count;
        for (index = 0; index < n_registers; index++) begin
            write_reg(index, $random(seed));
            check_reg(index);
        end
        write_reg(enable_gen_pkg::reg_enable, 32'h0);
        report_test("register write and read-back", errors_before);
    endtask

    task automatic test_out_of_range();
        int errors_before;
        int n;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0] resp;
        errors_before = error_count;
        for (n = 0; n < 6; n++) begin
            // The words just below and just above the block come first
            if (n == 0) begin
                addr = base_address - 32'h4;
            end else if (n == 1) begin
                addr = base_address + 32'(4 * n_registers);
            end else begin
                addr = $random(seed);
                if (address_in_block(addr)) addr = base_address + 32'h10 + {24'h0, addr[7:0]};
            end
            axil_write(addr, $random(seed), resp);
            compare_resp(resp, axil_pkg::resp_slverr, "out-of-range write response");
            axil_read(addr, data, resp);
            compare_resp(resp, axil_pkg::resp_slverr, "out-of-range read response");
            compare_data(data, 32'h0, "out-of-range read");
        end
        for (n = 0; n < n_registers; n++) begin
            check_reg(n);
        end
        report_test("out-of-range access", errors_before);
    endtask

    task automatic test_external_enable();
        int errors_before;
        int round;
        int period;
        errors_before = error_count;
        gen_enable_in = 1'b0;
        for (round = 0; round < 3; round++) begin
            period = 4 + random_below(37);
            write_reg(enable_gen_pkg::reg_period, period);
            write_reg(enable_gen_pkg::reg_threshold_1, random_below(period + 1));
            // The first round always puts threshold 2 past the period, where it never fires
            if (round == 0 || random_below(2) == 1) begin
                write_reg(enable_gen_pkg::reg_threshold_2, period + 1 + random_below(50));
            end else begin
                write_reg(enable_gen_pkg::reg_threshold_2, random_below(period + 1));
            end
            gen_enable_in = 1'b1;
            idle_cycles(4 * (period + 1));
            gen_enable_in = 1'b0;
            idle_cycles(5);
        end
        report_test("pulse timing under external enable", errors_before);
    endtask

    task automatic test_bus_enable();
        int errors_before;
        int round;
        int n;
        errors_before = error_count;
        gen_enable_in = 1'b0;
        write_reg(enable_gen_pkg::reg_period, 5 + random_below(8));
        write_reg(enable_gen_pkg::reg_threshold_1, random_below(5));
        write_reg(enable_gen_pkg::reg_threshold_2, random_below(5));
        for (round = 0; round < 3; round++) begin
            write_reg(enable_gen_pkg::reg_enable, 32'h1);
            idle_cycles(10 + random_below(40));
            write_reg(enable_gen_pkg::reg_enable, 32'h0);
            idle_cycles(5 + random_below(10));
        end
        // External toggles must not disturb a counter held on by the bus bit
        write_reg(enable_gen_pkg::reg_enable, 32'h1);
        for (n = 0; n < 80; n++) begin
            if (random_below(8) == 0) gen_enable_in = !gen_enable_in;
            next_cycle();
        end
        write_reg(enable_gen_pkg::reg_enable, 32'h0);
        for (n = 0; n < 40; n++) begin
            if (random_below(8) == 0) gen_enable_in = !gen_enable_in;
            next_cycle();
        end
        gen_enable_in = 1'b0;
        idle_cycles(5);
        report_test("bus enable and disable", errors_before);
    endtask

    task automatic test_reprogram();
        int errors_before;
        int round;
        int index;
        errors_before = error_count;
        gen_enable_in = 1'b1;
        for (round = 0; round < 8; round++) begin
            index = 1 + random_below(3);
            if (index == enable_gen_pkg::reg_period) begin
                write_reg(index, 3 + random_below(28));
            end else begin
                write_reg(index, random_below(32));
            end
            idle_cycles(random_below(20));
            check_reg(1 + random_below(3));
        end
        gen_enable_in = 1'b0;
        idle_cycles(5);
        report_test("reprogramming while running", errors_before);
    endtask

    initial begin : main
        seed = 32'h16f79794;
        rst = 1'b1;
        gen_enable_in = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (5) @(posedge clock);
        #2;
        rst = 1'b0;
        test_reset_values();
        test_readback();
        test_out_of_range();
        test_external_enable();
        test_bus_enable();
        test_reprogram();
        $display("tests run: %0d, passed: %0d, failed: %0d", pass_count + fail_count,
            pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- enable_generator.f
common/axil_pkg.sv
common/enable_gen_pkg.sv
axil_register_cu/axil_register_cu.sv
hdl/enable_generator_counter.sv
hdl/enable_comparator.sv
hdl/enable_generator_2.sv
verif/enable_generator_tb.sv

//--- Bender.yml
package:
  name: enable_generator

sources:
  # Packages come first, the RTL depends on them
  - files:
      - common/axil_pkg.sv
      - common/enable_gen_pkg.sv
      - axil_register_cu/axil_register_cu.sv
      - hdl/enable_generator_counter.sv
      - hdl/enable_comparator.sv
      - hdl/enable_generator_2.sv
  - target: test
    files:
      - verif/enable_generator_tb.sv
